//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv_exec_slice
FILELIST  ?= rv_exec_slice.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf $(BUILD_DIR)

//--- rv_exec_slice.f
rv_pkg.sv
rv_idu.sv
rv_regfile.sv
rv_exu.sv
rv_exec_slice.sv
tb_rv_exec_slice.sv

//--- rv_exec_slice.sv
module rv_exec_slice (
   input  logic                    i_clk,
   input  logic                    i_rst_n,
   input  logic                    i_valid,
   input  logic [rv_pkg::ILEN-1:0] i_insn,
   input  logic [rv_pkg::XLEN-1:0] i_pc,
   output rv_pkg::exe_result_t     o_res
);
   import rv_pkg::*;

   dec_ctrl_t       ctrl;
   logic [XLEN-1:0] rs1_data;
   logic [XLEN-1:0] rs2_data;

   rv_idu u_idu (
      .i_insn  (i_insn),
      .i_valid (i_valid),
      .o_ctrl  (ctrl)
   );

   // operands are read from the raw fields while the word is still being decoded
   rv_regfile u_rf (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .i_rs1_addr (i_insn[19:15]),
      .i_rs2_addr (i_insn[24:20]),
      .o_rs1_data (rs1_data),
      .o_rs2_data (rs2_data),
      .i_we       (o_res.rf_we),
      .i_wr_addr  (o_res.rd),
      .i_wr_data  (o_res.result)
   );

   rv_exu u_exu (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .i_ctrl     (ctrl),
      .i_pc       (i_pc),
      .i_rs1_data (rs1_data),
      .i_rs2_data (rs2_data),
      .o_res      (o_res)
   );

endmodule

//--- rv_exu.sv
module rv_exu (
   input  logic                    i_clk,
   input  logic                    i_rst_n,
   input  rv_pkg::dec_ctrl_t       i_ctrl,
   input  logic [rv_pkg::XLEN-1:0] i_pc,
   input  logic [rv_pkg::XLEN-1:0] i_rs1_data,
   input  logic [rv_pkg::XLEN-1:0] i_rs2_data,
   output rv_pkg::exe_result_t     o_res
);
   import rv_pkg::*;

   logic [XLEN-1:0] op_a;
   logic [XLEN-1:0] rs2;
   logic [XLEN-1:0] op_b;
   logic [XLEN-1:0] sum;
   logic [XLEN-1:0] diff;
   logic [XLEN-1:0] pc_plus4;
   logic [XLEN-1:0] pc_plus_imm;
   logic [XLEN-1:0] alu;
   logic [XLEN-1:0] next_pc;
   logic [31:0]     w_res;
   logic [5:0]      shamt;
   logic [4:0]      shamt_w;
   logic            lt;
   logic            ltu;
   logic            br_eq;
   logic            br_lt;
   logic            br_ltu;
   logic            taken;
   exe_result_t     res_d;

   assign op_a = i_ctrl.rs1_re ? i_rs1_data : '0;
   assign rs2  = i_ctrl.rs2_re ? i_rs2_data : '0;
   assign op_b = (i_ctrl.op_sel == OP_SEL_RF) ? rs2 : i_ctrl.imm;

   assign sum         = op_a + op_b;
   assign diff        = op_a - op_b;
   assign pc_plus4    = i_pc + XLEN'(4);
   assign pc_plus_imm = i_pc + i_ctrl.imm;
   assign shamt       = op_b[5:0];
   assign shamt_w     = op_b[4:0];
   assign lt          = $signed(op_a) < $signed(op_b);
   assign ltu         = op_a < op_b;

   // branches compare the registers while op_b carries the offset
   assign br_eq  = (op_a == rs2);
   assign br_lt  = $signed(op_a) < $signed(rs2);
   assign br_ltu = op_a < rs2;

   // W forms work on the low word only
   always_comb begin
      case (i_ctrl.fu_sel)
         FU_SUBW: w_res = diff[31:0];
         FU_SLLW: w_res = op_a[31:0] << shamt_w;
         FU_SRLW: w_res = op_a[31:0] >> shamt_w;
         FU_SRAW: w_res = $signed(op_a[31:0]) >>> shamt_w;
         default: w_res = sum[31:0];
      endcase
   end

   always_comb begin
      alu   = '0;
      taken = 1'b0;
      case (i_ctrl.fu_sel)
         FU_LUI:   alu = op_b;
         FU_AUIPC: alu = pc_plus_imm;
         FU_JAL, FU_JALR: begin
            alu   = pc_plus4;
            taken = 1'b1;
         end
         FU_BEQ:   taken = br_eq;
         FU_BNE:   taken = ~br_eq;
         FU_BLT:   taken = br_lt;
         FU_BGE:   taken = ~br_lt;
         FU_BLTU:  taken = br_ltu;
         FU_BGEU:  taken = ~br_ltu;
         FU_ADD:   alu = sum;
         FU_SUB:   alu = diff;
         FU_AND:   alu = op_a & op_b;
         FU_OR:    alu = op_a | op_b;
         FU_XOR:   alu = op_a ^ op_b;
         FU_SLL:   alu = op_a << shamt;
         FU_SRL:   alu = op_a >> shamt;
         FU_SRA:   alu = $signed(op_a) >>> shamt;
         FU_SLT:   alu = {{(XLEN-1){1'b0}}, lt};
         FU_SLTU:  alu = {{(XLEN-1){1'b0}}, ltu};
         FU_ADDW, FU_SUBW, FU_SLLW, FU_SRLW, FU_SRAW: begin
            alu = {{(XLEN-32){w_res[31]}}, w_res};
         end
         default:  alu = '0;
      endcase
   end

   // jalr targets rs1+imm with bit 0 cleared while other redirects are pc-relative
   always_comb begin
      if (i_ctrl.fu_sel == FU_JALR) begin
         next_pc = {sum[XLEN-1:1], 1'b0};
      end else if (taken) begin
         next_pc = pc_plus_imm;
      end else begin
         next_pc = pc_plus4;
      end
   end

   always_comb begin
      res_d           = '0;
      res_d.valid     = 1'b1;
      res_d.illegal   = i_ctrl.illegal;
      res_d.rd        = i_ctrl.rd;
      res_d.rf_we     = i_ctrl.rf_we;
      res_d.result    = alu;
      res_d.next_pc   = next_pc;
      res_d.br_taken  = taken;
      res_d.mem_load  = i_ctrl.mem_load;
      res_d.mem_store = i_ctrl.mem_store;
      res_d.mem_size  = i_ctrl.mem_size;
   end

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_res <= '0;
      end else if (i_ctrl.valid) begin
         o_res <= res_d;
      end else begin
         // an idle cycle leaves a bubble with no side effects
         o_res.valid     <= 1'b0;
         o_res.illegal   <= 1'b0;
         o_res.rf_we     <= 1'b0;
         o_res.br_taken  <= 1'b0;
         o_res.mem_load  <= 1'b0;
         o_res.mem_store <= 1'b0;
      end
   end

endmodule

//--- rv_idu.sv
module rv_idu (
   input  logic [rv_pkg::ILEN-1:0] i_insn,
   input  logic                    i_valid,
   output rv_pkg::dec_ctrl_t       o_ctrl
);
   import rv_pkg::*;

   logic [6:0]        opcode;
   logic [REG_AW-1:0] rd;
   logic [2:0]        funct3;
   logic [6:0]        funct7;
   logic              legal;
   logic [XLEN-1:0]   imm_i;
   logic [XLEN-1:0]   imm_s;
   logic [XLEN-1:0]   imm_b;
   logic [XLEN-1:0]   imm_u;
   logic [XLEN-1:0]   imm_j;
   logic [XLEN-1:0]   imm_sh;

   assign opcode = i_insn[6:0];
   assign rd     = i_insn[11:7];
   assign funct3 = i_insn[14:12];
   assign funct7 = i_insn[31:25];

   // every immediate format, already extended to XLEN
   assign imm_i  = {{(XLEN-12){i_insn[31]}}, i_insn[31:20]};
   assign imm_s  = {{(XLEN-12){i_insn[31]}}, i_insn[31:25], i_insn[11:7]};
   assign imm_b  = {{(XLEN-13){i_insn[31]}}, i_insn[31], i_insn[7], i_insn[30:25],
                    i_insn[11:8], 1'b0};
   assign imm_u  = {{(XLEN-32){i_insn[31]}}, i_insn[31:12], 12'b0};
   assign imm_j  = {{(XLEN-21){i_insn[31]}}, i_insn[31], i_insn[19:12], i_insn[20],
                    i_insn[30:21], 1'b0};
   assign imm_sh = {{(XLEN-6){1'b0}}, i_insn[25:20]};

   always_comb begin
      legal           = 1'b0;
      o_ctrl          = '0;
      o_ctrl.op_sel   = OP_SEL_NONE;
      o_ctrl.fu_sel   = FU_NONE;
      o_ctrl.mem_size = LSU_SIZE_8;
      case (opcode)
         OPC_LUI, OPC_AUIPC: begin
            legal         = 1'b1;
            o_ctrl.rf_we  = 1'b1;
            o_ctrl.op_sel = OP_SEL_IMM20_SL12;
            o_ctrl.fu_sel = (opcode == OPC_LUI) ? FU_LUI : FU_AUIPC;
            o_ctrl.imm    = imm_u;
         end
         OPC_JAL: begin
            legal         = 1'b1;
            o_ctrl.rf_we  = 1'b1;
            o_ctrl.op_sel = OP_SEL_IMM21_SEXT;
            o_ctrl.fu_sel = FU_JAL;
            o_ctrl.imm    = imm_j;
         end
         OPC_JALR: begin
            legal         = (funct3 == 3'b000);
            o_ctrl.rf_we  = 1'b1;
            o_ctrl.rs1_re = 1'b1;
            o_ctrl.op_sel = OP_SEL_IMM12_SEXT;
            o_ctrl.fu_sel = FU_JALR;
            o_ctrl.imm    = imm_i;
         end
         OPC_BRANCH: begin
            legal         = 1'b1;
            o_ctrl.rs1_re = 1'b1;
            o_ctrl.rs2_re = 1'b1;
            o_ctrl.op_sel = OP_SEL_IMM13_SEXT;
            o_ctrl.imm    = imm_b;
            case (funct3)
               3'b000:  o_ctrl.fu_sel = FU_BEQ;
               3'b001:  o_ctrl.fu_sel = FU_BNE;
               3'b100:  o_ctrl.fu_sel = FU_BLT;
               3'b101:  o_ctrl.fu_sel = FU_BGE;
               3'b110:  o_ctrl.fu_sel = FU_BLTU;
               3'b111:  o_ctrl.fu_sel = FU_BGEU;
               default: legal = 1'b0;
            endcase
         end
         OPC_LOAD: begin
            // funct3 111 has no load, 110 is lwu
            legal             = (funct3 != 3'b111);
            o_ctrl.rs1_re     = 1'b1;
            o_ctrl.op_sel     = OP_SEL_IMM12_SEXT;
            o_ctrl.fu_sel     = FU_ADD;
            o_ctrl.imm        = imm_i;
            o_ctrl.mem_load   = 1'b1;
            o_ctrl.mem_size   = lsu_size_e'(funct3[1:0]);
            o_ctrl.mem_sigext = ~funct3[2] & (funct3[1:0] != 2'b11);
         end
         OPC_STORE: begin
            legal            = ~funct3[2];
            o_ctrl.rs1_re    = 1'b1;
            o_ctrl.rs2_re    = 1'b1;
            o_ctrl.op_sel    = OP_SEL_IMM12_SEXT;
            o_ctrl.fu_sel    = FU_ADD;
            o_ctrl.imm       = imm_s;
            o_ctrl.mem_store = 1'b1;
            o_ctrl.mem_size  = lsu_size_e'(funct3[1:0]);
         end
         OPC_OP_IMM: begin
            legal         = 1'b1;
            o_ctrl.rf_we  = 1'b1;
            o_ctrl.rs1_re = 1'b1;
            o_ctrl.op_sel = OP_SEL_IMM12_SEXT;
            o_ctrl.imm    = imm_i;
            case (funct3)
               3'b000: o_ctrl.fu_sel = FU_ADD;
               3'b010: o_ctrl.fu_sel = FU_SLT;
               3'b011: o_ctrl.fu_sel = FU_SLTU;
               3'b100: o_ctrl.fu_sel = FU_XOR;
               3'b110: o_ctrl.fu_sel = FU_OR;
               3'b111: o_ctrl.fu_sel = FU_AND;
               3'b001: begin
                  // 64-bit shifts take a 6-bit shamt, so only funct7[6:1] is checked
                  legal         = (funct7[6:1] == F7_BASE[6:1]);
                  o_ctrl.op_sel = OP_SEL_SHAMT_ZEXT;
                  o_ctrl.imm    = imm_sh;
                  o_ctrl.fu_sel = FU_SLL;
               end
               default: begin
                  legal         = (funct7[6:1] == F7_BASE[6:1]) |
                                  (funct7[6:1] == F7_ALT[6:1]);
                  o_ctrl.op_sel = OP_SEL_SHAMT_ZEXT;
                  o_ctrl.imm    = imm_sh;
                  o_ctrl.fu_sel = funct7[5] ? FU_SRA : FU_SRL;
               end
            endcase
         end
         OPC_OP: begin
            legal         = 1'b1;
            o_ctrl.rf_we  = 1'b1;
            o_ctrl.rs1_re = 1'b1;
            o_ctrl.rs2_re = 1'b1;
            o_ctrl.op_sel = OP_SEL_RF;
            case ({funct7, funct3})
               {F7_BASE, 3'b000}: o_ctrl.fu_sel = FU_ADD;
               {F7_ALT, 3'b000}:  o_ctrl.fu_sel = FU_SUB;
               {F7_BASE, 3'b001}: o_ctrl.fu_sel = FU_SLL;
               {F7_BASE, 3'b010}: o_ctrl.fu_sel = FU_SLT;
               {F7_BASE, 3'b011}: o_ctrl.fu_sel = FU_SLTU;
               {F7_BASE, 3'b100}: o_ctrl.fu_sel = FU_XOR;
               {F7_BASE, 3'b101}: o_ctrl.fu_sel = FU_SRL;
               {F7_ALT, 3'b101}:  o_ctrl.fu_sel = FU_SRA;
               {F7_BASE, 3'b110}: o_ctrl.fu_sel = FU_OR;
               {F7_BASE, 3'b111}: o_ctrl.fu_sel = FU_AND;
               default:           legal = 1'b0;
            endcase
         end
         OPC_OP_IMM_32: begin
            o_ctrl.rf_we  = 1'b1;
            o_ctrl.rs1_re = 1'b1;
            o_ctrl.op_sel = OP_SEL_SHAMT_ZEXT;
            o_ctrl.imm    = imm_sh;
            case (funct3)
               3'b000: begin
                  legal         = 1'b1;
                  o_ctrl.op_sel = OP_SEL_IMM12_SEXT;
                  o_ctrl.imm    = imm_i;
                  o_ctrl.fu_sel = FU_ADDW;
               end
               3'b001: begin
                  legal         = (funct7 == F7_BASE);
                  o_ctrl.fu_sel = FU_SLLW;
               end
               3'b101: begin
                  legal         = (funct7 == F7_BASE) | (funct7 == F7_ALT);
                  o_ctrl.fu_sel = funct7[5] ? FU_SRAW : FU_SRLW;
               end
               default: legal = 1'b0;
            endcase
         end
         OPC_OP_32: begin
            legal         = 1'b1;
            o_ctrl.rf_we  = 1'b1;
            o_ctrl.rs1_re = 1'b1;
            o_ctrl.rs2_re = 1'b1;
            o_ctrl.op_sel = OP_SEL_RF;
            case ({funct7, funct3})
               {F7_BASE, 3'b000}: o_ctrl.fu_sel = FU_ADDW;
               {F7_ALT, 3'b000}:  o_ctrl.fu_sel = FU_SUBW;
               {F7_BASE, 3'b001}: o_ctrl.fu_sel = FU_SLLW;
               {F7_BASE, 3'b101}: o_ctrl.fu_sel = FU_SRLW;
               {F7_ALT, 3'b101}:  o_ctrl.fu_sel = FU_SRAW;
               default:           legal = 1'b0;
            endcase
         end
         default: legal = 1'b0;
      endcase

      // an unmatched word must not touch any state downstream
      if (!legal) begin
         o_ctrl.rf_we      = 1'b0;
         o_ctrl.rs1_re     = 1'b0;
         o_ctrl.rs2_re     = 1'b0;
         o_ctrl.mem_load   = 1'b0;
         o_ctrl.mem_store  = 1'b0;
         o_ctrl.mem_sigext = 1'b0;
         o_ctrl.op_sel     = OP_SEL_NONE;
         o_ctrl.fu_sel     = FU_NONE;
         o_ctrl.imm        = '0;
      end
      o_ctrl.valid   = i_valid;
      o_ctrl.illegal = ~legal;
      o_ctrl.rd      = rd;
   end

endmodule

//--- rv_pkg.sv
package rv_pkg;

   localparam int XLEN   = 64;
   localparam int ILEN   = 32;
   localparam int NREGS  = 32;
   localparam int REG_AW = $clog2(NREGS);

   // major opcodes of the RV64I base and W-form groups
   localparam logic [6:0] OPC_LUI       = 7'b0110111;
   localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
   localparam logic [6:0] OPC_JAL       = 7'b1101111;
   localparam logic [6:0] OPC_JALR      = 7'b1100111;
   localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
   localparam logic [6:0] OPC_LOAD      = 7'b0000011;
   localparam logic [6:0] OPC_STORE     = 7'b0100011;
   localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
   localparam logic [6:0] OPC_OP        = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
   localparam logic [6:0] OPC_OP_32     = 7'b0111011;

   // funct7 values that separate add/sub and logical/arithmetic shifts
   localparam logic [6:0] F7_BASE = 7'b0000000;
   localparam logic [6:0] F7_ALT  = 7'b0100000;

   // source of operand B and the immediate format behind it
   typedef enum logic [2:0] {
      OP_SEL_RF,
      OP_SEL_IMM12_SEXT,
      OP_SEL_SHAMT_ZEXT,
      OP_SEL_IMM13_SEXT,
      OP_SEL_IMM20_SL12,
      OP_SEL_IMM21_SEXT,
      OP_SEL_NONE
   } op_sel_e;

   typedef enum logic [4:0] {
      FU_LUI,
      FU_AUIPC,
      FU_JAL,
      FU_JALR,
      FU_BEQ,
      FU_BNE,
      FU_BLT,
      FU_BGE,
      FU_BLTU,
      FU_BGEU,
      FU_ADD,
      FU_SUB,
      FU_AND,
      FU_OR,
      FU_XOR,
      FU_SLL,
      FU_SRL,
      FU_SRA,
      FU_SLT,
      FU_SLTU,
      FU_ADDW,
      FU_SUBW,
      FU_SLLW,
      FU_SRLW,
      FU_SRAW,
      FU_NONE
   } fu_sel_e;

   // log2 of the access size in bytes, same as funct3[1:0] of loads and stores
   typedef enum logic [1:0] {
      LSU_SIZE_1 = 2'd0,
      LSU_SIZE_2 = 2'd1,
      LSU_SIZE_4 = 2'd2,
      LSU_SIZE_8 = 2'd3
   } lsu_size_e;

   typedef struct packed {
      logic              valid;
      logic              illegal;
      logic              rf_we;
      logic [REG_AW-1:0] rd;
      logic              rs1_re;
      logic              rs2_re;
      op_sel_e           op_sel;
      fu_sel_e           fu_sel;
      logic              mem_load;
      logic              mem_store;
      logic              mem_sigext;
      lsu_size_e         mem_size;
      logic [XLEN-1:0]   imm;
   } dec_ctrl_t;

   // br_taken is set for every redirect, jumps included
   typedef struct packed {
      logic              valid;
      logic              illegal;
      logic [REG_AW-1:0] rd;
      logic              rf_we;
      logic [XLEN-1:0]   result;
      logic [XLEN-1:0]   next_pc;
      logic              br_taken;
      logic              mem_load;
      logic              mem_store;
      lsu_size_e         mem_size;
   } exe_result_t;

endpackage

//--- rv_regfile.sv
module rv_regfile (
   input  logic                      i_clk,
   input  logic                      i_rst_n,
   input  logic [rv_pkg::REG_AW-1:0] i_rs1_addr,
   input  logic [rv_pkg::REG_AW-1:0] i_rs2_addr,
   output logic [rv_pkg::XLEN-1:0]   o_rs1_data,
   output logic [rv_pkg::XLEN-1:0]   o_rs2_data,
   input  logic                      i_we,
   input  logic [rv_pkg::REG_AW-1:0] i_wr_addr,
   input  logic [rv_pkg::XLEN-1:0]   i_wr_data
);
   import rv_pkg::*;

   // x0 has no storage
   logic [XLEN-1:0] regs [1:NREGS-1];

   // the pending write is visible to a read in the same cycle
   function automatic logic [XLEN-1:0] read_port(input logic [REG_AW-1:0] addr);
      logic [XLEN-1:0] data;
      if (addr == '0) begin
         data = '0;
      end else if (i_we && (i_wr_addr == addr)) begin
         data = i_wr_data;
      end else begin
         data = regs[addr];
      end
      return data;
   endfunction

   always_comb begin
      o_rs1_data = read_port(i_rs1_addr);
      o_rs2_data = read_port(i_rs2_addr);
   end

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         for (int i = 1; i < NREGS; i++) begin
            regs[i] <= '0;
         end
      end else if (i_we && (i_wr_addr != '0)) begin
         regs[i_wr_addr] <= i_wr_data;
      end
   end

endmodule

//--- tb_rv_exec_slice.sv
module tb_rv_exec_slice;
   timeunit 1ns;
   timeprecision 1ps;
   import rv_pkg::*;

   localparam int          CLK_PERIOD = 8;
   localparam int          NUM_INSN   = 4000;
   localparam logic [63:0] START_PC   = 64'h0000_0000_8000_0000;

   logic            clk = 1'b0;
   logic            rst_n;
   logic            in_valid;
   logic [31:0]     in_insn;
   logic [XLEN-1:0] in_pc;
   exe_result_t     res;

   logic [63:0] rng;
   logic [63:0] xreg [0:NREGS-1];
   logic [63:0] model_pc;

   rv_exec_slice uut (
      .i_clk   (clk),
      .i_rst_n (rst_n),
      .i_valid (in_valid),
      .i_insn  (in_insn),
      .i_pc    (in_pc),
      .o_res   (res)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   function automatic logic [63:0] xorshift(input logic [63:0] s);
      logic [63:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 7);
      x = x ^ (x << 17);
      return x;
   endfunction

   task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
      if (exp !== act) begin
         $display("** Error %s: expected %h, actual %h", name, exp, act);
         $display("CHECKS FAILED");
         $fatal(1, "stopped at the first mismatch");
      end
   endtask

   // registers come from x0..x7 so that back-to-back dependencies are frequent
   task automatic draw_insn(output logic v, output logic [31:0] w);
      logic [63:0] r;
      logic [4:0]  rd;
      logic [4:0]  rs1;
      logic [4:0]  rs2;
      logic [2:0]  f3;
      logic [2:0]  f3w;
      logic [6:0]  f7;
      rng = xorshift(rng);
      r   = rng;
      rng = xorshift(rng);
      rd  = {2'b00, r[6:4]};
      rs1 = {2'b00, r[9:7]};
      rs2 = {2'b00, r[12:10]};
      f3  = r[15:13];
      f3w = (r[14:13] == 2'd0) ? 3'b000 : ((r[14:13] == 2'd1) ? 3'b001 : 3'b101);
      f7  = r[16] ? F7_ALT : F7_BASE;
      v   = 1'b1;
      case (r[3:0])
         4'd0:  w = rng[31:0];
         4'd1:  w = {rng[19:0], rd, OPC_LUI};
         4'd2:  w = {rng[19:0], rd, OPC_AUIPC};
         4'd3:  w = {rng[19:0], rd, OPC_JAL};
         4'd4:  w = {rng[11:0], rs1, 3'b000, rd, OPC_JALR};
         4'd5:  w = {rng[6:0], rs2, rs1, f3, rng[11:7], OPC_BRANCH};
         4'd6:  w = {rng[11:0], rs1, f3, rd, OPC_LOAD};
         4'd7:  w = {rng[6:0], rs2, rs1, 1'b0, f3[1:0], rng[11:7], OPC_STORE};
         4'd8, 4'd9: begin
            if (f3 == 3'b001 || f3 == 3'b101) begin
               w = {f7[6:1], rng[5:0], rs1, f3, rd, OPC_OP_IMM};
            end else begin
               w = {rng[11:0], rs1, f3, rd, OPC_OP_IMM};
            end
         end
         4'd10, 4'd11: begin
            w = {(f3 == 3'b000 || f3 == 3'b101) ? f7 : F7_BASE, rs2, rs1, f3, rd, OPC_OP};
         end
         4'd12: begin
            if (f3w == 3'b000) begin
               w = {rng[11:0], rs1, f3w, rd, OPC_OP_IMM_32};
            end else begin
               w = {(f3w == 3'b101) ? f7 : F7_BASE, rng[4:0], rs1, f3w, rd, OPC_OP_IMM_32};
            end
         end
         4'd13: w = {(f3w != 3'b001) ? f7 : F7_BASE, rs2, rs1, f3w, rd, OPC_OP_32};
         4'd14: begin
            // idle cycle with a junk word on the bus
            v = 1'b0;
            w = rng[31:0];
         end
         default: w = {rng[11:0], rs1, 3'b000, rd, OPC_OP_IMM};
      endcase
   endtask

   // reference model of one RV64I instruction
   task automatic predict(input logic [31:0] w, input logic [63:0] pc,
                          output exe_result_t e, output bit res_known);
      logic [6:0]  opc;
      logic [2:0]  f3;
      logic [6:0]  f7;
      logic [63:0] a;
      logic [63:0] b;
      logic [63:0] imm_i;
      logic [63:0] imm_s;
      logic [63:0] imm_b;
      logic [63:0] imm_u;
      logic [63:0] imm_j;
      logic [63:0] r;
      logic [31:0] rw;
      logic        ok;
      logic        we;
      logic        tk;
      opc       = w[6:0];
      f3        = w[14:12];
      f7        = w[31:25];
      a         = xreg[w[19:15]];
      b         = xreg[w[24:20]];
      imm_i     = {{52{w[31]}}, w[31:20]};
      imm_s     = {{52{w[31]}}, w[31:25], w[11:7]};
      imm_b     = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
      imm_u     = {{32{w[31]}}, w[31:12], 12'h000};
      imm_j     = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      e         = '0;
      e.valid   = 1'b1;
      e.rd      = w[11:7];
      e.next_pc = pc + 64'd4;
      r         = '0;
      rw        = '0;
      ok        = 1'b1;
      we        = 1'b0;
      tk        = 1'b0;
      res_known = 1'b1;
      case (opc)
         7'b0110111: begin
            we = 1'b1;
            r  = imm_u;
         end
         7'b0010111: begin
            we = 1'b1;
            r  = pc + imm_u;
         end
         7'b1101111: begin
            we        = 1'b1;
            tk        = 1'b1;
            r         = pc + 64'd4;
            e.next_pc = pc + imm_j;
         end
         7'b1100111: begin
            ok        = (f3 == 3'b000);
            we        = 1'b1;
            tk        = 1'b1;
            r         = pc + 64'd4;
            e.next_pc = (a + imm_i) & ~64'd1;
         end
         7'b1100011: begin
            res_known = 1'b0;
            case (f3)
               3'b000:  tk = (a == b);
               3'b001:  tk = (a != b);
               3'b100:  tk = ($signed(a) < $signed(b));
               3'b101:  tk = ($signed(a) >= $signed(b));
               3'b110:  tk = (a < b);
               3'b111:  tk = (a >= b);
               default: ok = 1'b0;
            endcase
            if (tk) begin
               e.next_pc = pc + imm_b;
            end
         end
         7'b0000011: begin
            ok         = (f3 != 3'b111);
            r          = a + imm_i;
            e.mem_load = 1'b1;
            e.mem_size = lsu_size_e'(f3[1:0]);
         end
         7'b0100011: begin
            ok          = ~f3[2];
            r           = a + imm_s;
            e.mem_store = 1'b1;
            e.mem_size  = lsu_size_e'(f3[1:0]);
         end
         7'b0010011: begin
            we = 1'b1;
            case (f3)
               3'b000: r = a + imm_i;
               3'b010: r = ($signed(a) < $signed(imm_i)) ? 64'd1 : 64'd0;
               3'b011: r = (a < imm_i) ? 64'd1 : 64'd0;
               3'b100: r = a ^ imm_i;
               3'b110: r = a | imm_i;
               3'b111: r = a & imm_i;
               3'b001: begin
                  ok = (w[31:26] == 6'b000000);
                  r  = a << w[25:20];
               end
               default: begin
                  ok = (w[31:26] == 6'b000000) || (w[31:26] == 6'b010000);
                  if (w[30]) begin
                     r = $signed(a) >>> w[25:20];
                  end else begin
                     r = a >> w[25:20];
                  end
               end
            endcase
         end
         7'b0110011: begin
            we = 1'b1;
            case ({f7, f3})
               {7'h00, 3'b000}: r = a + b;
               {7'h20, 3'b000}: r = a - b;
               {7'h00, 3'b001}: r = a << b[5:0];
               {7'h00, 3'b010}: r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
               {7'h00, 3'b011}: r = (a < b) ? 64'd1 : 64'd0;
               {7'h00, 3'b100}: r = a ^ b;
               {7'h00, 3'b101}: r = a >> b[5:0];
               {7'h20, 3'b101}: r = $signed(a) >>> b[5:0];
               {7'h00, 3'b110}: r = a | b;
               {7'h00, 3'b111}: r = a & b;
               default:         ok = 1'b0;
            endcase
         end
         7'b0011011: begin
            we = 1'b1;
            case (f3)
               3'b000: rw = a[31:0] + imm_i[31:0];
               3'b001: begin
                  ok = (f7 == 7'h00);
                  rw = a[31:0] << w[24:20];
               end
               3'b101: begin
                  ok = (f7 == 7'h00) || (f7 == 7'h20);
                  if (f7[5]) begin
                     rw = $signed(a[31:0]) >>> w[24:20];
                  end else begin
                     rw = a[31:0] >> w[24:20];
                  end
               end
               default: ok = 1'b0;
            endcase
            r = {{32{rw[31]}}, rw};
         end
         7'b0111011: begin
            we = 1'b1;
            case ({f7, f3})
               {7'h00, 3'b000}: rw = a[31:0] + b[31:0];
               {7'h20, 3'b000}: rw = a[31:0] - b[31:0];
               {7'h00, 3'b001}: rw = a[31:0] << b[4:0];
               {7'h00, 3'b101}: rw = a[31:0] >> b[4:0];
               {7'h20, 3'b101}: rw = $signed(a[31:0]) >>> b[4:0];
               default:         ok = 1'b0;
            endcase
            r = {{32{rw[31]}}, rw};
         end
         default: ok = 1'b0;
      endcase
      // illegal words report pc+4 and touch nothing
      if (!ok) begin
         we          = 1'b0;
         tk          = 1'b0;
         res_known   = 1'b0;
         e.mem_load  = 1'b0;
         e.mem_store = 1'b0;
         e.next_pc   = pc + 64'd4;
      end
      e.illegal  = ~ok;
      e.rf_we    = we;
      e.br_taken = tk;
      e.result   = r;
   endtask

   task automatic verify_result(input int n, input logic [31:0] w, input exe_result_t e,
                                input bit res_known);
      string tag;
      tag = $sformatf("insn %0d (%08h)", n, w);
      check_val({tag, " valid"}, 64'(e.valid), 64'(res.valid));
      check_val({tag, " illegal"}, 64'(e.illegal), 64'(res.illegal));
      check_val({tag, " rf_we"}, 64'(e.rf_we), 64'(res.rf_we));
      check_val({tag, " br_taken"}, 64'(e.br_taken), 64'(res.br_taken));
      check_val({tag, " mem_load"}, 64'(e.mem_load), 64'(res.mem_load));
      check_val({tag, " mem_store"}, 64'(e.mem_store), 64'(res.mem_store));
      check_val({tag, " next_pc"}, e.next_pc, res.next_pc);
      if (e.rf_we) begin
         check_val({tag, " rd"}, 64'(e.rd), 64'(res.rd));
      end
      if (res_known) begin
         check_val({tag, " result"}, e.result, res.result);
      end
      if (e.mem_load || e.mem_store) begin
         check_val({tag, " mem_size"}, 64'(e.mem_size), 64'(res.mem_size));
      end
   endtask

   // a cycle without a result must not write, redirect or access memory
   task automatic expect_bubble(input string tag);
      check_val({tag, " valid"}, 64'd0, 64'(res.valid));
      check_val({tag, " rf_we"}, 64'd0, 64'(res.rf_we));
      check_val({tag, " br_taken"}, 64'd0, 64'(res.br_taken));
      check_val({tag, " mem_load"}, 64'd0, 64'(res.mem_load));
      check_val({tag, " mem_store"}, 64'd0, 64'(res.mem_store));
   endtask

   initial begin
      #((NUM_INSN + 20) * CLK_PERIOD);
      $display("timeout: the watchdog expired before all instructions were checked");
      $display("CHECKS FAILED");
      $fatal(1, "run aborted by the watchdog");
   end

   initial begin
      exe_result_t pend;
      bit          pend_known;
      logic        pend_valid;
      logic [31:0] pend_word;
      int          pend_n;
      logic        nxt_valid;
      logic [31:0] nxt_word;
      logic [63:0] cur_pc;
      rng        = 64'd27169;
      rst_n      = 1'b0;
      in_valid   = 1'b0;
      in_insn    = '0;
      in_pc      = '0;
      model_pc   = START_PC;
      pend       = '0;
      pend_known = 1'b0;
      pend_valid = 1'b0;
      pend_word  = '0;
      pend_n     = 0;
      for (int i = 0; i < NREGS; i++) begin
         xreg[i] = '0;
      end
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      expect_bubble("after reset");
      draw_insn(nxt_valid, nxt_word);
      for (int n = 0; n <= NUM_INSN; n++) begin
         @(posedge clk);
         in_valid <= nxt_valid;
         in_insn  <= nxt_word;
         in_pc    <= model_pc;
         cur_pc = model_pc;
         // o_res now carries the instruction driven one edge earlier
         @(negedge clk);
         if (pend_valid) begin
            verify_result(pend_n, pend_word, pend, pend_known);
            if (pend.rf_we && (pend.rd != 5'd0)) begin
               xreg[pend.rd] = pend.result;
            end
         end else begin
            expect_bubble($sformatf("idle before insn %0d", n));
         end
         pend_valid = nxt_valid;
         if (nxt_valid) begin
            predict(nxt_word, cur_pc, pend, pend_known);
            pend_word = nxt_word;
            pend_n    = n;
            model_pc  = pend.next_pc;
         end
         if (n >= NUM_INSN - 1) begin
            nxt_valid = 1'b0;
            nxt_word  = '0;
         end else begin
            draw_insn(nxt_valid, nxt_word);
         end
      end
      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule
